// ==== design/bus_pkg.sv ====
package bus_pkg;

    // Internal register bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Address space select in bits 15:12
    typedef enum logic [3:0] {
        SPACE_REGS   = 4'h0,    // Global and channel registers
        SPACE_SAMPLE = 4'h1     // Block sample buffer
    } space_e;

    // Global register offsets, group 0
    typedef enum logic [3:0] {
        OFF_STATUS    = 4'h0,
        OFF_TIMESTAMP = 4'h1,
        OFF_COMMAND   = 4'h2
    } glb_off_e;

    // Per-channel register offsets, groups 1 to 4
    typedef enum logic [3:0] {
        OFF_DAC    = 4'h0,
        OFF_LIMIT  = 4'h1,
        OFF_CTRL   = 4'h2,
        OFF_OUTPUT = 4'h3      // Read-only clipped setpoint
    } reg_off_e;

    localparam logic [DATA_W-1:0] CMD_SAMPLE = 32'd1;  // Starts a block sample

    function automatic space_e addr_space(input logic [ADDR_W-1:0] addr);
        return space_e'(addr[15:12]);
    endfunction

    function automatic logic [3:0] addr_grp(input logic [ADDR_W-1:0] addr);
        return addr[7:4];       // 0 global, else channel + 1
    endfunction

    function automatic logic [3:0] addr_off(input logic [ADDR_W-1:0] addr);
        return addr[3:0];
    endfunction

endpackage

// ==== design/board_pkg.sv ====
package board_pkg;

    localparam int NUM_CHAN   = 4;                  // Motor channels
    localparam int CHAN_W     = $clog2(NUM_CHAN);   // Channel index width
    localparam int DAC_W      = 16;                 // Signed setpoint
    localparam int LIMIT_W    = 15;                 // Unsigned current limit
    localparam int BOARD_ID_W = 4;
    localparam int WORD_W     = 32;                 // Timestamp and buffer word

    // Block sample buffer layout
    localparam int SMP_DEPTH    = 5;
    localparam int SMP_IDX_W    = 3;
    localparam int SMP_TS_ENTRY = 0;    // Channel outputs follow in entries 1 to 4

    // Status word fields
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_ID_LSB   = 24;   // Board id in bits 27:24

    // Channel output widened to a full word
    function automatic logic [WORD_W-1:0] sext_out(input logic signed [DAC_W-1:0] val);
        return WORD_W'(val);
    endfunction

endpackage

// ==== design/reg_bus_if.sv ====
interface reg_bus_if import bus_pkg::*; ();

    // Read channel
    logic              rreq;    // Held with raddr until rack
    logic [ADDR_W-1:0] raddr;
    logic              rack;    // One-cycle pulse with rdata
    logic [DATA_W-1:0] rdata;

    // Write channel
    logic              wen;     // One-cycle strobe
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;

    // Host side
    modport bridge (
        output rreq, raddr, wen, waddr, wdata,
        input  rack, rdata
    );

    // Register file side
    modport board (
        input  rreq, raddr, wen, waddr, wdata,
        output rack, rdata
    );

endinterface

// ==== design/axil_reg_bridge.sv ====
module axil_reg_bridge import bus_pkg::*; (
    input  logic                  sysclk,
    input  logic                  rst,
    reg_bus_if.bridge             bus,

    // AXI4-Lite write address and data
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [ADDR_W-1:0]     awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [DATA_W/8-1:0]   wstrb,    // Full-word stores only
    // Write response
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    // Read address and data
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [ADDR_W-1:0]     araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_W-1:0]     rdata,
    output logic [1:0]            rresp
);

    typedef enum logic [2:0] {IDLE, WRITE, WRESP, READ, RRESP} state_e;

    state_e state;
    logic   aw_hs;      // AW and W taken together
    logic   ar_hs;

    assign aw_hs = awready && awvalid && wvalid;
    assign ar_hs = arready && arvalid;

    assign bresp = 2'b00;   // Always OKAY
    assign rresp = 2'b00;

    // One transaction at a time
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state    <= IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            arready  <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            bus.wen  <= 1'b0;
            bus.rreq <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (aw_hs) begin
                        awready <= 1'b0;
                        wready  <= 1'b0;
                        bus.wen <= 1'b1;          // Store on next edge
                        state   <= WRITE;
                    end else if (ar_hs) begin
                        arready  <= 1'b0;
                        bus.rreq <= 1'b1;
                        state    <= READ;
                    end else if (!awready && !arready) begin
                        // Writes win when both arrive together
                        if (awvalid && wvalid) begin
                            awready <= 1'b1;
                            wready  <= 1'b1;
                        end else if (arvalid) begin
                            arready <= 1'b1;
                        end
                    end
                end
                WRITE: begin
                    bus.wen <= 1'b0;
                    bvalid  <= 1'b1;
                    state   <= WRESP;
                end
                WRESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                READ: begin
                    if (bus.rack) begin               // Board answered
                        bus.rreq <= 1'b0;
                        rvalid   <= 1'b1;
                        state    <= RRESP;
                    end
                end
                RRESP: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address, data and response payload
    always_ff @(posedge sysclk) begin
        if (aw_hs && state == IDLE) begin
            bus.waddr <= awaddr;
            bus.wdata <= wdata;
        end
        if (ar_hs && state == IDLE) bus.raddr <= araddr;
        if (bus.rack && state == READ) rdata <= bus.rdata;   // Held until RREADY
    end

endmodule

// ==== design/block_sampler.sv ====
module block_sampler import board_pkg::*; (
    input  logic                    sysclk,
    input  logic                    rst,
    input  logic                    sample_start,   // From COMMAND write
    output logic                    sample_busy,
    output logic [SMP_IDX_W-1:0]    sample_chan,    // Channel being copied
    input  logic signed [DAC_W-1:0] chan_output,
    input  logic [WORD_W-1:0]       timestamp,
    input  logic [SMP_IDX_W-1:0]    buf_raddr,
    output logic [WORD_W-1:0]       buf_rdata
);

    typedef enum logic {SMP_IDLE, SMP_RUN} smp_state_e;

    smp_state_e           state;
    logic [SMP_IDX_W-1:0] idx;                      // Entry written this cycle
    logic [WORD_W-1:0]    smp_buf [SMP_DEPTH];      // Kept until next sample

    // Walk the buffer once per start
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= SMP_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                SMP_IDLE: begin
                    if (sample_start) begin
                        state <= SMP_RUN;
                        idx   <= '0;
                    end
                end
                SMP_RUN: begin
                    idx <= idx + 1'b1;
                    if (idx == SMP_IDX_W'(SMP_DEPTH - 1)) state <= SMP_IDLE;  // Last entry
                end
                default: state <= SMP_IDLE;
            endcase
        end
    end

    assign sample_busy = (state == SMP_RUN);

    // Entry 1 holds channel 0
    assign sample_chan = (idx == SMP_IDX_W'(SMP_TS_ENTRY)) ? '0 : idx - 1'b1;

    // Timestamp first, then the sign-extended outputs
    always_ff @(posedge sysclk) begin
        if (state == SMP_RUN) begin
            if (idx == SMP_IDX_W'(SMP_TS_ENTRY)) smp_buf[idx] <= timestamp;
            else                                 smp_buf[idx] <= sext_out(chan_output);
        end
    end

    // Out-of-range entries read zero
    assign buf_rdata = (buf_raddr < SMP_DEPTH) ? smp_buf[buf_raddr] : '0;

endmodule

// ==== design/motor_board.sv ====
module motor_board import bus_pkg::*, board_pkg::*; (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic [BOARD_ID_W-1:0] board_id,
    reg_bus_if.board              bus
);

    logic signed [DAC_W-1:0]   dac      [NUM_CHAN];   // Setpoints
    logic        [LIMIT_W-1:0] limit    [NUM_CHAN];   // Current limits
    logic        [NUM_CHAN-1:0] amp_en;               // CTRL bit 0
    logic signed [DAC_W-1:0]   chan_out [NUM_CHAN];   // Clipped, registered
    logic        [WORD_W-1:0]  timestamp;
    logic        [DATA_W-1:0]  status_word;
    logic        [DATA_W-1:0]  rd_mux;

    // Address decode
    logic [3:0]        w_grp, w_off, r_grp, r_off;
    logic [CHAN_W-1:0] w_chan, r_chan;
    logic              cmd_sample;
    logic              rd_hold, rd_fire;

    // Sampler hookup
    logic                    sample_start, sample_busy;
    logic [SMP_IDX_W-1:0]    sample_chan;
    logic signed [DAC_W-1:0] smp_out;
    logic [WORD_W-1:0]       buf_rdata;

    assign w_grp  = addr_grp(bus.waddr);
    assign w_off  = addr_off(bus.waddr);
    assign w_chan = CHAN_W'(w_grp - 4'd1);     // Group 1 is channel 0
    assign r_grp  = addr_grp(bus.raddr);
    assign r_off  = addr_off(bus.raddr);
    assign r_chan = CHAN_W'(r_grp - 4'd1);

    assign cmd_sample = glb_off_e'(w_off) == OFF_COMMAND && bus.wdata == CMD_SAMPLE;

    // Setpoint clamped to +/- limit, zero when amplifier off
    function automatic logic signed [DAC_W-1:0] clip_dac(
        input logic signed [DAC_W-1:0] sp,
        input logic [LIMIT_W-1:0]      lim,
        input logic                    en
    );
        logic signed [DAC_W-1:0] hi;
        hi = $signed({1'b0, lim});
        if (!en)       return '0;
        if (sp > hi)   return hi;
        if (sp < -hi)  return -hi;
        return sp;
    endfunction

    // Host register writes
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                dac[i]   <= '0;
                limit[i] <= '0;
            end
            amp_en       <= '0;
            sample_start <= 1'b0;
        end else begin
            sample_start <= 1'b0;                         // Pulse only
            if (bus.wen && addr_space(bus.waddr) == SPACE_REGS) begin
                if (w_grp == 4'd0) begin
                    if (cmd_sample && !sample_busy) sample_start <= 1'b1;   // Ignored when busy
                end else if (w_grp <= NUM_CHAN) begin
                    case (reg_off_e'(w_off))
                        OFF_DAC:   dac[w_chan]    <= bus.wdata[DAC_W-1:0];
                        OFF_LIMIT: limit[w_chan]  <= bus.wdata[LIMIT_W-1:0];
                        OFF_CTRL:  amp_en[w_chan] <= bus.wdata[0];
                        default:   ;                              // OUTPUT is read-only
                    endcase
                end
            end
        end
    end

    // Outputs lag register changes by one cycle
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CHAN; i++) chan_out[i] <= '0;
            timestamp <= '0;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                chan_out[i] <= clip_dac(dac[i], limit[i], amp_en[i]);
            end
            timestamp <= timestamp + 1'b1;                // Free-running
        end
    end

    always_comb begin
        status_word = '0;
        status_word[STATUS_ID_LSB +: BOARD_ID_W] = board_id;
        status_word[STATUS_BUSY_BIT]             = sample_busy;
    end

    // Read mux, unmapped addresses give zero
    always_comb begin
        rd_mux = '0;
        case (addr_space(bus.raddr))
            SPACE_REGS: begin
                if (r_grp == 4'd0) begin
                    case (glb_off_e'(r_off))
                        OFF_STATUS:    rd_mux = status_word;
                        OFF_TIMESTAMP: rd_mux = timestamp;
                        default:       rd_mux = '0;       // COMMAND reads zero
                    endcase
                end else if (r_grp <= NUM_CHAN) begin
                    case (reg_off_e'(r_off))
                        OFF_DAC:    rd_mux = sext_out(dac[r_chan]);
                        OFF_LIMIT:  rd_mux = DATA_W'(limit[r_chan]);
                        OFF_CTRL:   rd_mux = DATA_W'(amp_en[r_chan]);
                        OFF_OUTPUT: rd_mux = sext_out(chan_out[r_chan]);
                        default:    rd_mux = '0;
                    endcase
                end
            end
            SPACE_SAMPLE: rd_mux = buf_rdata;
            default:      rd_mux = '0;
        endcase
    end

    // Buffer reads wait out a running sample, start pulse included
    assign rd_hold = addr_space(bus.raddr) == SPACE_SAMPLE && (sample_busy || sample_start);
    assign rd_fire = bus.rreq && !bus.rack && !rd_hold;

    always_ff @(posedge sysclk) begin
        if (rst) bus.rack <= 1'b0;
        else     bus.rack <= rd_fire;
    end

    always_ff @(posedge sysclk) begin
        if (rd_fire) bus.rdata <= rd_mux;
    end

    assign smp_out = (sample_chan < NUM_CHAN) ? chan_out[sample_chan[CHAN_W-1:0]] : '0;

    block_sampler sampler_i (
        .sysclk       (sysclk),
        .rst          (rst),
        .sample_start (sample_start),
        .sample_busy  (sample_busy),
        .sample_chan  (sample_chan),
        .chan_output  (smp_out),
        .timestamp    (timestamp),
        .buf_raddr    (bus.raddr[SMP_IDX_W-1:0]),
        .buf_rdata    (buf_rdata)
    );

endmodule

// ==== design/motor_ctrl_top.sv ====
module motor_ctrl_top import bus_pkg::*, board_pkg::*; (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic [BOARD_ID_W-1:0] board_id,   // Rotary switch value

    // AXI4-Lite slave
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [ADDR_W-1:0]     awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [DATA_W/8-1:0]   wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [ADDR_W-1:0]     araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_W-1:0]     rdata,
    output logic [1:0]            rresp
);

    reg_bus_if reg_bus ();      // Bridge to board register bus

    // Host side
    axil_reg_bridge bridge_i (
        .sysclk  (sysclk),
        .rst     (rst),
        .bus     (reg_bus.bridge),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    // Channel and global registers plus sampler
    motor_board board_i (
        .sysclk   (sysclk),
        .rst      (rst),
        .board_id (board_id),
        .bus      (reg_bus.board)
    );

endmodule

// ==== testbench/axil_proto_chk.sv ====
module axil_proto_chk (
    input logic        sysclk,
    input logic        rst,
    input logic        awvalid, awready,
    input logic        wvalid, wready,
    input logic        bvalid, bready,
    input logic        arvalid, arready,
    input logic        rvalid, rready,
    input logic [31:0] rdata,
    input logic        wen,     // Register bus write strobe
    input logic        rreq     // Register bus read request
);
    timeunit 1ns;
    timeprecision 1ps;

    // Host side valids wait for their ready
    aw_hold: assert property (@(posedge sysclk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("AWVALID dropped before AWREADY");
    w_hold: assert property (@(posedge sysclk) disable iff (rst) wvalid && !wready |=> wvalid)
        else $error("WVALID dropped before WREADY");
    ar_hold: assert property (@(posedge sysclk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("ARVALID dropped before ARREADY");

    // Responses held until taken
    b_hold: assert property (@(posedge sysclk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("BVALID dropped before BREADY");
    r_hold: assert property (@(posedge sysclk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("RVALID dropped before RREADY");
    r_stable: assert property (@(posedge sysclk) disable iff (rst)
                              rvalid && !rready |=> $stable(rdata))
        else $error("RDATA changed while RVALID waited");

    // Quiet response channels out of reset
    rst_quiet: assert property (@(posedge sysclk) rst |=> !bvalid && !rvalid)
        else $error("Response valid high after reset");

    // Single outstanding operation on the register bus
    bus_excl: assert property (@(posedge sysclk) disable iff (rst) !(wen && rreq))
        else $error("Register bus write and read at the same time");

endmodule

// ==== testbench/motor_ctrl_tb.sv ====
module motor_ctrl_tb import bus_pkg::*, board_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS      = 10;
    localparam int DRV_DLY     = 1;     // Input skew after the rising edge
    localparam int RST_CYCLES  = 8;
    localparam int SEED        = 64;
    localparam int MAX_STALL   = 5;     // BREADY and RREADY back-pressure
    localparam int NUM_RAND_WR = 300;
    localparam int SMP_EVERY   = 25;    // Random writes between block samples
    localparam int NUM_BAD_WR  = 24;
    localparam int NUM_BAD_RD  = 12;
    // Reset check, random writes with two reads each, samples, ignored accesses
    localparam int NUM_TXN = 17 + NUM_RAND_WR * 3 + (NUM_RAND_WR / SMP_EVERY) * 7
                           + NUM_BAD_WR + 17 + NUM_BAD_RD;
    localparam int WDOG_NS = (NUM_TXN * 200 + RST_CYCLES) * CLK_NS;

    localparam logic [BOARD_ID_W-1:0] BOARD_ID    = 4'hA;
    localparam logic [ADDR_W-1:0]     ADDR_STATUS = 16'h0000;
    localparam logic [ADDR_W-1:0]     ADDR_CMD    = 16'h0002;
    localparam logic [ADDR_W-1:0]     SMP_BASE    = {SPACE_SAMPLE, 12'h000};
    localparam logic [DATA_W-1:0]     STATUS_IDLE = DATA_W'(BOARD_ID) << STATUS_ID_LSB;

    logic                  sysclk, rst;
    logic [BOARD_ID_W-1:0] board_id;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    logic [ADDR_W-1:0]     awaddr, araddr;
    logic [DATA_W-1:0]     wdata, rdata;
    logic [DATA_W/8-1:0]   wstrb;
    logic [1:0]            bresp, rresp;

    // Reference copy of the channel registers
    logic signed [DAC_W-1:0]   m_dac [NUM_CHAN];
    logic        [LIMIT_W-1:0] m_lim [NUM_CHAN];
    logic                      m_en  [NUM_CHAN];
    logic        [DATA_W-1:0]  prev_ts;    // Timestamp entry of the last sample

    motor_ctrl_top motor_ctrl_top_i (.*);

    bind axil_reg_bridge axil_proto_chk proto_chk_i (
        .sysclk (sysclk), .rst (rst),
        .awvalid (awvalid), .awready (awready), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready), .arvalid (arvalid), .arready (arready),
        .rvalid (rvalid), .rready (rready), .rdata (rdata),
        .wen (bus.wen), .rreq (bus.rreq)
    );

    always #(CLK_NS / 2) sysclk = ~sysclk;

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // Handshakes sampled at the falling edge, taken at the next rising edge
    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input int max_stall);
        int stall;
        stall = $urandom_range(max_stall);
        @(posedge sysclk);
        #DRV_DLY;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        do @(negedge sysclk); while (!(awready && wready));
        @(posedge sysclk);
        #DRV_DLY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(negedge sysclk); while (!bvalid);
        check_eq("write response", 32'(2'b00), 32'(bresp));
        repeat (stall) @(posedge sysclk);     // Host not ready yet
        @(posedge sysclk);
        #DRV_DLY bready = 1'b1;
        @(posedge sysclk);
        #DRV_DLY bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int stall;
        stall = $urandom_range(MAX_STALL);
        @(posedge sysclk);
        #DRV_DLY;
        arvalid = 1'b1;
        araddr  = addr;
        do @(negedge sysclk); while (!arready);
        @(posedge sysclk);
        #DRV_DLY arvalid = 1'b0;
        do @(negedge sysclk); while (!rvalid);  // Buffer reads may be held off
        data = rdata;
        check_eq("read response", 32'(2'b00), 32'(rresp));
        repeat (stall) @(posedge sysclk);
        @(posedge sysclk);
        #DRV_DLY rready = 1'b1;
        @(posedge sysclk);
        #DRV_DLY rready = 1'b0;
    endtask

    function automatic logic [ADDR_W-1:0] chan_addr(input int c, input logic [3:0] off);
        return {8'h00, 4'(c + 1), off};     // Group 1 is channel 0
    endfunction

    // Zero when disabled, else setpoint held within minus to plus limit
    function automatic logic [DATA_W-1:0] model_out(input int c);
        int sp;
        int lim;
        sp  = m_dac[c];
        lim = m_lim[c];
        if (!m_en[c])     return '0;
        if (sp > lim)     return lim;
        if (sp < -lim)    return -lim;
        return sp;
    endfunction

    function automatic logic [DATA_W-1:0] reg_expect(input int c, input logic [3:0] off);
        case (off)
            OFF_DAC:   return int'(m_dac[c]);    // Sign-extended setpoint
            OFF_LIMIT: return DATA_W'(m_lim[c]);
            OFF_CTRL:  return DATA_W'(m_en[c]);
            default:   return model_out(c);
        endcase
    endfunction

    function automatic logic [ADDR_W-1:0] unmapped_addr();
        logic [ADDR_W-1:0] a;
        a = 16'($urandom);
        if ($urandom_range(1)) begin
            a[15:12] = 4'($urandom_range(15, 2));    // Above the sample space
        end else begin
            a[15:12] = SPACE_REGS;
            a[7:4]   = 4'($urandom_range(15, 5));    // Past the last channel
        end
        return a;
    endfunction

    task automatic verify_regs(input string name);
        logic [DATA_W-1:0] got;
        for (int c = 0; c < NUM_CHAN; c++) begin
            for (int off = 0; off < 4; off++) begin
                axil_read(chan_addr(c, 4'(off)), got);
                check_eq($sformatf("%s ch%0d off%0d", name, c, off), reg_expect(c, 4'(off)), got);
            end
        end
    endtask

    // Snapshot of the outputs at the command, read back at once
    task automatic run_sample();
        logic [DATA_W-1:0] snap [NUM_CHAN];
        logic [DATA_W-1:0] got;
        for (int c = 0; c < NUM_CHAN; c++) snap[c] = model_out(c);
        axil_write(ADDR_CMD, CMD_SAMPLE, 0);    // No stall, first read lands mid-sample
        // Last entry first, it is written in the final busy cycle
        for (int k = SMP_DEPTH - 1; k >= 1; k--) begin
            axil_read(SMP_BASE + 16'(k), got);
            check_eq($sformatf("sample entry %0d", k), snap[k-1], got);
        end
        axil_read(SMP_BASE, got);
        check_eq("sample timestamp order", 32'd1, 32'(got > prev_ts));
        prev_ts = got;
        axil_read(ADDR_STATUS, got);
        check_eq("status after sample", STATUS_IDLE, got);
    endtask

    task automatic random_write_test();
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] got;
        logic [3:0]        off;
        int                c;
        for (int i = 0; i < NUM_RAND_WR; i++) begin
            c    = $urandom_range(NUM_CHAN - 1);
            off  = 4'($urandom_range(2));     // DAC, LIMIT or CTRL
            data = $urandom;
            case (off)
                OFF_DAC:   m_dac[c] = data[DAC_W-1:0];
                OFF_LIMIT: m_lim[c] = data[LIMIT_W-1:0];
                default:   m_en[c]  = data[0];
            endcase
            axil_write(chan_addr(c, off), data, MAX_STALL);
            axil_read(chan_addr(c, off), got);
            check_eq($sformatf("readback ch%0d off%0d", c, off), reg_expect(c, off), got);
            axil_read(chan_addr(c, OFF_OUTPUT), got);
            check_eq($sformatf("output clip ch%0d", c), model_out(c), got);
            if ((i + 1) % SMP_EVERY == 0) run_sample();
        end
    endtask

    task automatic ignored_access_test();
        logic [DATA_W-1:0] got;
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < NUM_BAD_WR; i++) begin
            case ($urandom_range(2))
                0:       addr = chan_addr($urandom_range(NUM_CHAN - 1), OFF_OUTPUT);
                1:       addr = ADDR_STATUS;
                default: addr = unmapped_addr();
            endcase
            axil_write(addr, $urandom, MAX_STALL);
        end
        verify_regs("after ignored write");
        axil_read(ADDR_STATUS, got);
        check_eq("status after ignored write", STATUS_IDLE, got);
        for (int i = 0; i < NUM_BAD_RD; i++) begin
            addr = unmapped_addr();
            axil_read(addr, got);
            check_eq($sformatf("unmapped read %h", addr), '0, got);
        end
    endtask

    initial begin
        #WDOG_NS;
        $display("Watchdog expired, the bus transactions stopped making progress");
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation timeout");
    end

    initial begin
        logic [DATA_W-1:0] got;
        void'($urandom(SEED));
        sysclk   = 1'b0;
        rst      = 1'b1;
        board_id = BOARD_ID;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '1;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        prev_ts  = '0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            m_dac[c] = '0;
            m_lim[c] = '0;
            m_en[c]  = 1'b0;
        end
        repeat (RST_CYCLES) @(posedge sysclk);
        #DRV_DLY rst = 1'b0;

        verify_regs("after reset");      // Model starts at zero
        axil_read(ADDR_STATUS, got);
        check_eq("status after reset", STATUS_IDLE, got);
        random_write_test();
        ignored_access_test();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
design/bus_pkg.sv
design/board_pkg.sv
design/reg_bus_if.sv
design/axil_reg_bridge.sv
design/block_sampler.sv
design/motor_board.sv
design/motor_ctrl_top.sv
testbench/axil_proto_chk.sv
testbench/motor_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the register-bus core and its testbench, then run the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module motor_ctrl_tb -Mdir obj_dir -o motor_ctrl_sim -f build.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit "$status"
fi

./obj_dir/motor_ctrl_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0
